// File: common/xgmii_pkg.sv
// XLGMII bus definitions

`default_nettype none

package xgmii_pkg;

    // one bus word carries sixteen byte lanes, split into two 64-bit halves
    localparam int lanes = 16;
    localparam int half_lanes = 8;

    // full bus word and its per-lane control flags
    typedef logic [lanes*8-1:0] xgmii_data_t;
    typedef logic [lanes-1:0] xgmii_ctrl_t;

    // one 64-bit half of a bus word, used when realigning lane-0 frames
    typedef logic [half_lanes*8-1:0] xgmii_half_data_t;
    typedef logic [half_lanes-1:0] xgmii_half_ctrl_t;

    // a single lane character
    typedef logic [7:0] xgmii_char_t;

    // control characters, only meaningful when the lane's control flag is set
    localparam xgmii_char_t char_idle = 8'h07;
    localparam xgmii_char_t char_start = 8'hfb;
    localparam xgmii_char_t char_end = 8'hfd;

    // preamble and start frame delimiter as they sit in one 64-bit half
    // byte 0 is replaced by the start character on the wire, so only the
    // upper seven bytes can be compared
    localparam xgmii_half_data_t eth_preamble = 64'hd555_5555_5555_5555;

endpackage

`default_nettype wire

// File: common/rx_pkg.sv
// Receiver stream and state types

`default_nettype none

package rx_pkg;

    // byte mask of a full stream beat, also used for the end-of-frame mask
    // of a bus word since both have one bit per lane
    typedef logic [xgmii_pkg::lanes-1:0] keep_t;

    // end-of-frame mask for one half of a bus word
    typedef logic [xgmii_pkg::half_lanes-1:0] half_keep_t;

    // reception states of the frame FSM
    // unshifted frames start on lane 8 and map bus words straight onto beats
    // shifted frames start on lane 0 and need half-word realignment
    typedef enum logic [1:0] {
        rx_idle = 2'b00,
        rx_unshifted = 2'b10,
        rx_shifted = 2'b11
    } rx_state_t;

endpackage

`default_nettype wire

// File: common/xgmii_word_if.sv
// Delayed bus word interface

`default_nettype none

// carries the bus word from the front end to the frame FSM
// all fields are valid every cycle and there is no handshake
interface xgmii_word_if;

    // bus word and control flags delayed by one cycle
    xgmii_pkg::xgmii_data_t word_data;
    xgmii_pkg::xgmii_ctrl_t word_ctrl;

    // end mask of the delayed word, a bit is set for every lane in front of
    // the first terminate character
    rx_pkg::keep_t end_keep;

    // lookahead flag, taken from the undelayed word that follows word_data
    logic next_end_first;

    modport source (
        output word_data,
        output word_ctrl,
        output end_keep,
        output next_end_first
    );

    modport sink (
        input word_data,
        input word_ctrl,
        input end_keep,
        input next_end_first
    );

endinterface

`default_nettype wire

// File: xlgmii_rx/xlgmii_rx_frontend.sv
// XLGMII receive front end

`default_nettype none

module xlgmii_rx_frontend (
    input  logic                   clk,
    input  logic                   rst,
    input  xgmii_pkg::xgmii_data_t xgmii_data,
    input  xgmii_pkg::xgmii_ctrl_t xgmii_ctrl,
    xgmii_word_if.source           word
);

    // lane view of the undelayed bus word
    xgmii_pkg::xgmii_char_t [xgmii_pkg::lanes-1:0] bus_chars;

    // end mask of the undelayed word, registered together with the word
    rx_pkg::keep_t end_keep_comb;

    assign bus_chars = xgmii_data;

    // the FSM works one word behind the bus so that it can look at the next
    // word before it commits to a last beat
    // this keeps a frame from ending with an empty mask when the terminate
    // lands on lane 0 of the following word

    // lane-ordered scan of the undelayed word
    // every lane stays kept until the first terminate control character,
    // after which all higher lanes are dropped even if they hold data
    // only the final word of a frame can carry a terminate, so running the
    // scan on every word is harmless
    always_comb begin : end_scan
        logic kept;
        kept = 1'b1;
        for (int i = 0; i < xgmii_pkg::lanes; i++) begin
            if (xgmii_ctrl[i] && (bus_chars[i] == xgmii_pkg::char_end)) begin
                kept = 1'b0;
            end
            end_keep_comb[i] = kept;
        end
    end

    // the scan runs on the undelayed word and its result is registered with
    // the word, which takes the lane chain out of the FSM's critical path
    // reset fills the pipeline with an idle word so that the idle state sees
    // a clean gap on its first cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            word.word_data <= {xgmii_pkg::lanes{xgmii_pkg::char_idle}};
            word.word_ctrl <= '1;
            word.end_keep <= '1;
        end else begin
            word.word_data <= xgmii_data;
            word.word_ctrl <= xgmii_ctrl;
            word.end_keep <= end_keep_comb;
        end
    end

    // lookahead for the FSM
    // a terminate on lane 0 of the undelayed word means the delayed word is
    // the last one carrying payload, even though its own mask is still full
    assign word.next_end_first = xgmii_ctrl[0] && (bus_chars[0] == xgmii_pkg::char_end);

endmodule

`default_nettype wire

// File: xlgmii_rx/xlgmii_rx_fsm.sv
// XLGMII frame reception FSM

`default_nettype none

module xlgmii_rx_fsm (
    input  logic                   clk,
    input  logic                   rst,
    xgmii_word_if.sink             word,
    input  logic                   axis_tready,
    output logic                   axis_tvalid,
    output xgmii_pkg::xgmii_data_t axis_tdata,
    output rx_pkg::keep_t          axis_tkeep,
    output logic                   axis_tlast,
    output logic                   error_ready,
    output logic                   error_preamble,
    output logic                   error_xgmii
);

    localparam int lo_bits = xgmii_pkg::half_lanes * 8;
    localparam int all_bits = xgmii_pkg::lanes * 8;

    // a half word made of idle characters
    localparam xgmii_pkg::xgmii_half_data_t idle_half =
        {xgmii_pkg::half_lanes{xgmii_pkg::char_idle}};

    localparam rx_pkg::keep_t keep_full = '1;
    localparam rx_pkg::half_keep_t half_full = '1;
    localparam rx_pkg::half_keep_t half_none = '0;
    localparam xgmii_pkg::xgmii_half_data_t half_zero = '0;

    rx_pkg::rx_state_t state;

    // lane and half views of the delayed word
    xgmii_pkg::xgmii_char_t [xgmii_pkg::lanes-1:0] chars;
    xgmii_pkg::xgmii_half_data_t lo_data;
    xgmii_pkg::xgmii_half_data_t hi_data;
    xgmii_pkg::xgmii_half_ctrl_t lo_ctrl;
    xgmii_pkg::xgmii_half_ctrl_t hi_ctrl;
    rx_pkg::half_keep_t lo_keep;
    rx_pkg::half_keep_t hi_keep;

    // upper half of the previous word, a shifted beat is built from it and
    // the lower half of the current word
    xgmii_pkg::xgmii_half_data_t prev_data;
    xgmii_pkg::xgmii_half_ctrl_t prev_ctrl;
    rx_pkg::half_keep_t prev_keep;

    // set for one cycle after a frame was ended by the lookahead, so the
    // idle state accepts the terminate on lane 0 of the next word
    logic tolerate_end;

    // the end of a shifted frame sits in the upper half of the last word,
    // and those bytes still have to go out as a beat of their own
    logic leftover;

    // decoded conditions on the delayed word
    logic start_lo;
    logic start_hi;
    logic preamble_ok;
    logic lo_all_idle;
    logic rest_idle;
    logic first_ok;

    assign chars = word.word_data;
    assign lo_data = word.word_data[lo_bits-1:0];
    assign hi_data = word.word_data[all_bits-1:lo_bits];
    assign lo_ctrl = word.word_ctrl[xgmii_pkg::half_lanes-1:0];
    assign hi_ctrl = word.word_ctrl[xgmii_pkg::lanes-1:xgmii_pkg::half_lanes];
    assign lo_keep = word.end_keep[xgmii_pkg::half_lanes-1:0];
    assign hi_keep = word.end_keep[xgmii_pkg::lanes-1:xgmii_pkg::half_lanes];

    assign start_lo = word.word_ctrl[0] && (chars[0] == xgmii_pkg::char_start);
    assign start_hi = word.word_ctrl[xgmii_pkg::half_lanes]
        && (chars[xgmii_pkg::half_lanes] == xgmii_pkg::char_start);

    // lanes 1 to 7 must be data and equal the preamble with its delimiter
    assign preamble_ok = (word.word_ctrl[xgmii_pkg::half_lanes-1:1] == '0)
        && (lo_data[lo_bits-1:8] == xgmii_pkg::eth_preamble[lo_bits-1:8]);

    assign lo_all_idle = (lo_ctrl == '1) && (lo_data == idle_half);

    // gap check, lanes 1 to 15 must be idle and lane 0 is judged apart
    assign rest_idle = (word.word_ctrl[xgmii_pkg::lanes-1:1] == '1)
        && (word.word_data[all_bits-1:8] == {(xgmii_pkg::lanes-1){xgmii_pkg::char_idle}});
    assign first_ok = word.word_ctrl[0]
        && (chars[0] == (tolerate_end ? xgmii_pkg::char_end : xgmii_pkg::char_idle));

    // the upper half buffer is loaded on every word
    // the shifted state and the leftover beat only read it one cycle later
    always_ff @(posedge clk) begin
        prev_data <= hi_data;
        prev_ctrl <= hi_ctrl;
        prev_keep <= hi_keep;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rx_pkg::rx_idle;
            tolerate_end <= 1'b0;
            leftover <= 1'b0;
            axis_tvalid <= 1'b0;
            axis_tdata <= '0;
            axis_tkeep <= '0;
            axis_tlast <= 1'b0;
            error_ready <= 1'b0;
            error_preamble <= 1'b0;
            error_xgmii <= 1'b0;
        end else begin
            // no beat and no error unless a state below says otherwise
            axis_tvalid <= 1'b0;
            axis_tdata <= '0;
            axis_tkeep <= '0;
            axis_tlast <= 1'b0;
            error_ready <= 1'b0;
            error_preamble <= 1'b0;
            error_xgmii <= 1'b0;
            tolerate_end <= 1'b0;

            case (state)
                rx_pkg::rx_idle: begin
                    // finish a shifted frame whose end was in an upper half
                    if (leftover) begin
                        leftover <= 1'b0;
                        axis_tvalid <= 1'b1;
                        axis_tdata <= {half_zero, prev_data};
                        axis_tkeep <= {half_none, prev_keep};
                        axis_tlast <= 1'b1;
                        if (!axis_tready) begin
                            error_ready <= 1'b1;
                        end
                        // control characters in the kept leftover lanes are
                        // not seen by the shifted state, so check them here
                        if ((prev_ctrl & prev_keep) != '0) begin
                            error_xgmii <= 1'b1;
                        end
                    end

                    if (start_lo) begin
                        // a frame with a broken preamble is dropped and its
                        // remaining words show up as gap errors
                        if (preamble_ok) begin
                            // a short frame ends in the upper half of its start
                            // word and goes out whole as the leftover beat
                            if (hi_keep != half_full) begin
                                leftover <= 1'b1;
                            end else begin
                                state <= rx_pkg::rx_shifted;
                            end
                        end else begin
                            error_preamble <= 1'b1;
                        end
                    end else if (start_hi) begin
                        // the lower half must be part of the gap, but the
                        // frame itself is still taken
                        if (!lo_all_idle) begin
                            error_xgmii <= 1'b1;
                        end
                        state <= rx_pkg::rx_unshifted;
                    end else if (!(rest_idle && first_ok)) begin
                        error_xgmii <= 1'b1;
                    end
                end

                rx_pkg::rx_unshifted: begin
                    // a terminate straight after the preamble leaves no payload,
                    // which counts as a missing preamble
                    if (word.end_keep == '0) begin
                        error_preamble <= 1'b1;
                        state <= rx_pkg::rx_idle;
                    end else begin
                        axis_tvalid <= 1'b1;
                        axis_tdata <= word.word_data;
                        if (!axis_tready) begin
                            error_ready <= 1'b1;
                        end

                        if (word.end_keep != keep_full) begin
                            axis_tlast <= 1'b1;
                            axis_tkeep <= word.end_keep;
                            state <= rx_pkg::rx_idle;
                        end else if (word.next_end_first) begin
                            // frame ends on the word boundary, close it now and
                            // let idle swallow the terminate
                            axis_tlast <= 1'b1;
                            axis_tkeep <= keep_full;
                            tolerate_end <= 1'b1;
                            state <= rx_pkg::rx_idle;
                        end else begin
                            axis_tkeep <= keep_full;
                        end

                        // kept lanes must all be data
                        if ((word.word_ctrl & word.end_keep) != '0) begin
                            error_xgmii <= 1'b1;
                            axis_tlast <= 1'b1;
                            state <= rx_pkg::rx_idle;
                        end
                    end
                end

                rx_pkg::rx_shifted: begin
                    // beat is the previous upper half followed by this lower half
                    axis_tvalid <= 1'b1;
                    axis_tdata <= {lo_data, prev_data};
                    if (!axis_tready) begin
                        error_ready <= 1'b1;
                    end

                    // the two masks come from different bus words, so a
                    // frame end is looked for in three places in turn
                    if (lo_keep != half_full) begin
                        axis_tlast <= 1'b1;
                        axis_tkeep <= {lo_keep, half_full};
                        state <= rx_pkg::rx_idle;
                    end else if (word.word_ctrl[xgmii_pkg::half_lanes]
                                 && (chars[xgmii_pkg::half_lanes] == xgmii_pkg::char_end)) begin
                        // the next beat would start with the terminate and be empty
                        axis_tlast <= 1'b1;
                        axis_tkeep <= keep_full;
                        state <= rx_pkg::rx_idle;
                    end else if (hi_keep != half_full) begin
                        // the end lies in the upper half, which idle sends out
                        axis_tkeep <= keep_full;
                        leftover <= 1'b1;
                        state <= rx_pkg::rx_idle;
                    end else begin
                        axis_tkeep <= keep_full;
                    end

                    // the lower half only counts while the buffered half is
                    // fully kept
                    if (((prev_ctrl & prev_keep) != '0)
                        || ((prev_keep == half_full) && ((lo_ctrl & lo_keep) != '0))) begin
                        error_xgmii <= 1'b1;
                        axis_tlast <= 1'b1;
                        leftover <= 1'b0;
                        state <= rx_pkg::rx_idle;
                    end
                end

                default: begin
                    state <= rx_pkg::rx_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/xlgmii_axis_rx.sv
// XLGMII to AXI4-Stream receiver

`default_nettype none

module xlgmii_axis_rx (
    input  logic                   clk,
    input  logic                   rst,

    // 128-bit XLGMII receive bus
    input  xgmii_pkg::xgmii_data_t xgmii_data,
    input  xgmii_pkg::xgmii_ctrl_t xgmii_ctrl,

    // AXI4-Stream output, the sink cannot stall the bus
    input  logic                   axis_tready,
    output logic                   axis_tvalid,
    output xgmii_pkg::xgmii_data_t axis_tdata,
    output rx_pkg::keep_t          axis_tkeep,
    output logic                   axis_tlast,

    // one-cycle error pulses
    output logic                   error_ready,
    output logic                   error_preamble,
    output logic                   error_xgmii
);

    // delayed word, end mask and lookahead between the two stages
    xgmii_word_if word_bus ();

    // first stage delays the bus by one word and scans for the frame end
    xlgmii_rx_frontend u_frontend (
        .clk        (clk),
        .rst        (rst),
        .xgmii_data (xgmii_data),
        .xgmii_ctrl (xgmii_ctrl),
        .word       (word_bus)
    );

    // second stage decodes frames and drives the stream with registered outputs
    xlgmii_rx_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .word           (word_bus),
        .axis_tready    (axis_tready),
        .axis_tvalid    (axis_tvalid),
        .axis_tdata     (axis_tdata),
        .axis_tkeep     (axis_tkeep),
        .axis_tlast     (axis_tlast),
        .error_ready    (error_ready),
        .error_preamble (error_preamble),
        .error_xgmii    (error_xgmii)
    );

endmodule

`default_nettype wire

// File: sim/tb_frames.svh
// Frame and fault generators

// lanes of the words being built, each entry holds {ctrl, char}
logic [8:0] lane_q[$];

// one bus word, changed shortly after the rising edge
task automatic drive_word(input xgmii_pkg::xgmii_data_t data, input xgmii_pkg::xgmii_ctrl_t ctrl);
    @(posedge clk);
    #10;
    xgmii_data = data;
    xgmii_ctrl = ctrl;
endtask

task automatic drive_idle();
    drive_word({xgmii_pkg::lanes{xgmii_pkg::char_idle}}, '1);
endtask

task automatic put_lane(input logic ctrl, input xgmii_pkg::xgmii_char_t ch);
    lane_q.push_back({ctrl, ch});
endtask

// pads the open word with idles, then drives the collected lanes word by word
task automatic flush_lanes();
    xgmii_pkg::xgmii_data_t data;
    xgmii_pkg::xgmii_ctrl_t ctrl;
    logic [8:0] entry;
    while (lane_q.size() % xgmii_pkg::lanes != 0) begin
        put_lane(1'b1, xgmii_pkg::char_idle);
    end
    while (lane_q.size() > 0) begin
        for (int i = 0; i < xgmii_pkg::lanes; i++) begin
            entry = lane_q.pop_front();
            ctrl[i] = entry[8];
            data[i*8 +: 8] = entry[7:0];
        end
        drive_word(data, ctrl);
    end
endtask

// one frame followed by a fully idle word
// a lane-8 frame has its seven preamble bytes in the upper half and the
// payload starts on the next word, a lane-0 frame puts payload from lane 8 on
// bad_lane flips a bit of that preamble lane, ctrl_at turns that payload
// byte into a control character, and a negative value leaves either alone
task automatic send_frame(input bit lane8, input int len, input int bad_lane, input int ctrl_at);
    xgmii_pkg::xgmii_char_t b;
    if (lane8) begin
        for (int i = 0; i < xgmii_pkg::half_lanes; i++) begin
            put_lane(1'b1, xgmii_pkg::char_idle);
        end
    end
    put_lane(1'b1, xgmii_pkg::char_start);
    for (int i = 1; i < xgmii_pkg::half_lanes; i++) begin
        b = xgmii_pkg::eth_preamble[i*8 +: 8];
        if (i == bad_lane) begin
            b = b ^ 8'h01;
        end
        put_lane(1'b0, b);
    end
    if (lane8) begin
        flush_lanes();
    end
    // the expected stream holds every byte between preamble and terminate
    for (int i = 0; i < len; i++) begin
        if (i == ctrl_at) begin
            b = 8'hfe;
        end else begin
            b = 8'($urandom);
        end
        put_lane(i == ctrl_at, b);
        byte_q.push_back(b);
    end
    put_lane(1'b1, xgmii_pkg::char_end);
    flush_lanes();
    drive_idle();
endtask

// an idle word with a data byte on one lane, then a clean idle word
task automatic send_gap_fault(input int lane);
    for (int i = 0; i < xgmii_pkg::lanes; i++) begin
        if (i == lane) begin
            put_lane(1'b0, 8'($urandom));
        end else begin
            put_lane(1'b1, xgmii_pkg::char_idle);
        end
    end
    flush_lanes();
    drive_idle();
endtask

// File: sim/tb_xlgmii_rx.sv
// XLGMII receiver testbench

`default_nettype none

module tb_xlgmii_rx;

    localparam int period = 100;
    localparam int reset_cycles = 16;
    localparam int test_count = 88;
    // longest frame plus the response wait and the settle words
    localparam int words_per_test = 24;
    localparam int wait_limit = 12;
    localparam int settle_words = 3;

    logic clk;
    logic rst;
    xgmii_pkg::xgmii_data_t xgmii_data;
    xgmii_pkg::xgmii_ctrl_t xgmii_ctrl;
    logic axis_tready;
    logic axis_tvalid;
    xgmii_pkg::xgmii_data_t axis_tdata;
    rx_pkg::keep_t axis_tkeep;
    logic axis_tlast;
    logic error_ready;
    logic error_preamble;
    logic error_xgmii;

    // payload bytes still expected on the stream, in order
    logic [7:0] byte_q[$];

    // what the monitor saw during the current test
    int beats;
    int last_count;
    int last_start;
    int bytes_seen;
    int pre_count;
    int xgmii_count;
    int ready_count;
    int errors;
    int tests;
    int test_errors;
    logic ready_at_edge;

    xlgmii_axis_rx uut (
        .clk            (clk),
        .rst            (rst),
        .xgmii_data     (xgmii_data),
        .xgmii_ctrl     (xgmii_ctrl),
        .axis_tready    (axis_tready),
        .axis_tvalid    (axis_tvalid),
        .axis_tdata     (axis_tdata),
        .axis_tkeep     (axis_tkeep),
        .axis_tlast     (axis_tlast),
        .error_ready    (error_ready),
        .error_preamble (error_preamble),
        .error_xgmii    (error_xgmii)
    );

    `include "tb_frames.svh"

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

    initial begin : watchdog
        #((reset_cycles + test_count * words_per_test + 50) * period);
        $display("ERROR %0t the tests did not finish in the expected time", $time);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic flag_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] observed);
        $display("FAIL %0t %s expected %h observed %h", $time, name, expected, observed);
        errors++;
    endtask

    task automatic flag_problem(input string msg);
        $display("ERROR %0t %s", $time, msg);
        errors++;
    endtask

    // the DUT registers error_ready from tready at the same edge as the beat
    always @(posedge clk) begin
        ready_at_edge <= axis_tready;
    end

    // outputs are registered on the rising edge, so they are read at the falling one
    always @(negedge clk) begin : monitor
        logic [7:0] exp_byte;
        if (!rst) begin
            assert (error_ready == (axis_tvalid && !ready_at_edge))
                else flag_mismatch("error_ready", 128'(axis_tvalid && !ready_at_edge),
                                   128'(error_ready));
            if (axis_tvalid) begin
                beats++;
                if (!axis_tlast) begin
                    assert (axis_tkeep == '1)
                        else flag_mismatch("axis_tkeep", 128'(16'hffff), 128'(axis_tkeep));
                end else begin
                    last_count++;
                    last_start = bytes_seen;
                    // a contiguous mask from lane 0 plus one has no bit in common with it
                    assert ((axis_tkeep != '0) && ((axis_tkeep & (axis_tkeep + 16'd1)) == '0))
                        else flag_problem("last beat mask is empty or has a gap");
                end
                for (int i = 0; i < xgmii_pkg::lanes; i++) begin
                    if (axis_tkeep[i]) begin
                        assert (byte_q.size() > 0)
                            else flag_problem("stream byte beyond the end of the payload");
                        if (byte_q.size() > 0) begin
                            exp_byte = byte_q.pop_front();
                            assert (axis_tdata[i*8 +: 8] == exp_byte)
                                else flag_mismatch("axis_tdata", 128'(exp_byte),
                                                   128'(axis_tdata[i*8 +: 8]));
                        end
                        bytes_seen++;
                    end
                end
            end else begin
                assert ((axis_tdata == '0) && (axis_tkeep == '0) && !axis_tlast)
                    else flag_problem("data, mask or last left set outside a beat");
            end
            if (error_ready) ready_count++;
            if (error_preamble) pre_count++;
            if (error_xgmii) xgmii_count++;
        end
    end

    task automatic begin_test();
        byte_q.delete();
        beats = 0;
        last_count = 0;
        last_start = 0;
        bytes_seen = 0;
        pre_count = 0;
        xgmii_count = 0;
        ready_count = 0;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        string verdict;
        if (errors == test_errors) begin
            verdict = "ok";
        end else begin
            verdict = "failed";
        end
        tests++;
        $display("test %0d %s %s", tests, name, verdict);
    endtask

    // kind 0 waits for the last beat, 1 for error_preamble, 2 for error_xgmii
    function automatic bit response_seen(input int kind);
        case (kind)
            0: return last_count > 0;
            1: return pre_count > 0;
            default: return xgmii_count > 0;
        endcase
    endfunction

    // idles the bus until the response shows up, then lets the pipeline drain
    task automatic idle_until(input int kind);
        int waited;
        waited = 0;
        while (!response_seen(kind) && waited < wait_limit) begin
            drive_idle();
            waited++;
        end
        assert (response_seen(kind)) else flag_problem("no response from the DUT in time");
        for (int i = 0; i < settle_words; i++) begin
            drive_idle();
        end
    endtask

    task automatic check_clean_frame();
        assert (last_count == 1)
            else flag_mismatch("axis_tlast count", 128'(1), 128'(last_count));
        assert (byte_q.size() == 0) else flag_problem("payload bytes missing from the stream");
        assert (pre_count == 0)
            else flag_mismatch("error_preamble count", 128'(0), 128'(pre_count));
        assert (xgmii_count == 0)
            else flag_mismatch("error_xgmii count", 128'(0), 128'(xgmii_count));
    endtask

    task automatic run_frame(input bit lane8, input int len, input string name);
        begin_test();
        send_frame(lane8, len, -1, -1);
        idle_until(0);
        check_clean_frame();
        end_test(name);
    endtask

    initial begin : stimulus
        int len;
        int lane;
        int p;
        void'($urandom(32'hdb77));
        rst = 1'b1;
        xgmii_data = {xgmii_pkg::lanes{xgmii_pkg::char_idle}};
        xgmii_ctrl = '1;
        axis_tready = 1'b1;
        errors = 0;
        tests = 0;
        begin_test();
        repeat (reset_cycles) @(posedge clk);
        #10;
        rst = 1'b0;

        // lane-8 starts, ends on every lane and twice on the word boundary
        for (int n = 1; n <= 32; n++) begin
            run_frame(1'b1, n, $sformatf("lane-8 frame of %0d bytes", n));
        end
        // lane-0 starts, ends inside the start word, in both halves, on lane 8
        // and on the boundary
        for (int n = 1; n <= 32; n++) begin
            run_frame(1'b0, n, $sformatf("lane-0 frame of %0d bytes", n));
        end
        for (int n = 0; n < 12; n++) begin
            len = $urandom_range(80, 1);
            run_frame(n % 2 == 0, len, $sformatf("random frame of %0d bytes", len));
        end

        for (int n = 0; n < 2; n++) begin
            begin_test();
            send_frame(1'b0, 40, $urandom_range(7, 1), -1);
            idle_until(1);
            assert (pre_count == 1)
                else flag_mismatch("error_preamble count", 128'(1), 128'(pre_count));
            assert (beats == 0) else flag_problem("beats issued for a frame with a bad preamble");
            end_test("bad preamble");
        end

        for (int n = 0; n < 4; n++) begin
            begin_test();
            lane = $urandom_range(15, 0);
            send_gap_fault(lane);
            idle_until(2);
            assert (xgmii_count == 1)
                else flag_mismatch("error_xgmii count", 128'(1), 128'(xgmii_count));
            assert (beats == 0) else flag_problem("beat issued for a corrupted idle word");
            end_test($sformatf("data on lane %0d of an idle word", lane));
        end

        // the stream must close no later than the beat carrying the bad lane
        for (int n = 0; n < 4; n++) begin
            begin_test();
            p = $urandom_range(39, 0);
            send_frame(n % 2 == 0, 40, -1, p);
            idle_until(0);
            assert (last_count == 1)
                else flag_mismatch("axis_tlast count", 128'(1), 128'(last_count));
            assert (last_start <= p) else flag_problem("last beat comes after the control byte");
            assert (xgmii_count >= 1) else flag_problem("no error_xgmii for a mid-frame control byte");
            end_test($sformatf("control byte at payload offset %0d", p));
        end

        for (int n = 0; n < 2; n++) begin
            begin_test();
            axis_tready = 1'b0;
            send_frame(n % 2 == 0, 50, -1, -1);
            idle_until(0);
            axis_tready = 1'b1;
            check_clean_frame();
            assert ((beats > 0) && (ready_count == beats))
                else flag_mismatch("error_ready count", 128'(beats), 128'(ready_count));
            end_test("frame with tready low");
        end

        $display("tests run %0d, failed checks %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
common/xgmii_pkg.sv
common/rx_pkg.sv
common/xgmii_word_if.sv
xlgmii_rx/xlgmii_rx_frontend.sv
xlgmii_rx/xlgmii_rx_fsm.sv
source/xlgmii_axis_rx.sv
sim/tb_xlgmii_rx.sv

// File: run.sh
#!/bin/sh
# builds the XLGMII receiver testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_xlgmii_rx -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_xlgmii_rx)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1
